// ==== mam_pkg.sv ====
package mam_pkg;

   localparam int ADDR_WIDTH = 32;
   localparam int ADDR_WORDS = 2;           // LS word first
   localparam int HDR_FLITS  = 2;           // Destination, then source
   localparam logic [5:0] SRC_TYPE = 6'b01_1111;

   // Flit selection for the response path
   localparam logic [1:0] SEL_DATA = 2'd0;
   localparam logic [1:0] SEL_DEST = 2'd1;
   localparam logic [1:0] SEL_SRC  = 2'd2;

   typedef struct packed {
      logic        valid;
      logic        last;
      logic [15:0] data;
   } dii_flit_t;

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } mam_op_e;

   typedef struct packed {
      mam_op_e                op;
      logic                   burst;
      logic [ADDR_WIDTH-1:0]  addr;
      logic [13:0]            beats;
   } mem_req_t;

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_HDR_SKIP,
      ST_CMD,
      ST_ADDR,
      ST_REQUEST,
      ST_WPKT_HDR,
      ST_WRITE,
      ST_WRITE_WAIT,
      ST_WSINGLE,
      ST_WSINGLE_WAIT,
      ST_RPKT_HDR,
      ST_READ
   } mam_state_e;

endpackage

// ==== mam_counter.sv ====
`timescale 1ns/1ps

module mam_counter #(
   parameter int DATA_WIDTH  = 32,
   parameter int MAX_PKT_LEN = 8
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            flit_clr,
   input  logic                            flit_inc,
   input  logic                            word_clr,
   input  logic                            word_inc,
   input  logic                            beat_load,
   input  logic                            beat_dec,
   input  logic [13:0]                     beats,
   output logic [$clog2(DATA_WIDTH/8)-1:0] word_idx,
   output logic                            addr_done,
   output logic                            wpkt_hdr_done,
   output logic                            word_done,
   output logic                            pkt_full,
   output logic                            beat_last
);

   localparam int FW = $clog2(MAX_PKT_LEN);
   localparam int WW = $clog2(DATA_WIDTH/8);
   localparam logic [FW-1:0] ADDR_END = FW'(mam_pkg::ADDR_WORDS - 1);
   localparam logic [FW-1:0] HDR_END  = FW'(mam_pkg::HDR_FLITS - 1);
   localparam logic [FW-1:0] PKT_END  = FW'(MAX_PKT_LEN - 1);
   localparam logic [WW-1:0] WORD_END = WW'(DATA_WIDTH/16 - 1);

   logic [FW-1:0] flit_cnt;                // Position in packet
   logic [13:0]   beat_cnt;                // Beats still to move

   always_ff @(posedge clk) begin
      if (rst) begin
         flit_cnt <= '0;
         word_idx <= '0;
         beat_cnt <= '0;
      end else begin
         if (flit_clr) flit_cnt <= '0;
         else if (flit_inc) flit_cnt <= flit_cnt + 1'b1;
         if (word_clr) word_idx <= '0;
         else if (word_inc) word_idx <= word_idx + 1'b1;
         if (beat_load) beat_cnt <= beats;
         else if (beat_dec) beat_cnt <= beat_cnt - 1'b1;
      end
   end

   assign addr_done = flit_cnt == ADDR_END;
   assign wpkt_hdr_done = flit_cnt == HDR_END;
   assign pkt_full = flit_cnt == PKT_END;
   assign word_done = word_idx == WORD_END;
   assign beat_last = beat_cnt == 14'd1;

endmodule

// ==== mam_wdata.sv ====
`timescale 1ns/1ps

module mam_wdata #(
   parameter int DATA_WIDTH = 32
) (
   input  logic                    clk,
   input  logic [15:0]             flit_data,
   input  logic                    shift,
   input  logic                    strb_load,
   input  logic                    burst,
   output logic [DATA_WIDTH-1:0]   write_data,
   output logic [DATA_WIDTH/8-1:0] write_strb
);

   logic [DATA_WIDTH/8-1:0] strb_q;        // From command flit

   // MS flit arrives first and ends up on top
   always_ff @(posedge clk) begin
      if (shift)
         write_data <= DATA_WIDTH'({write_data, flit_data});
      if (strb_load)
         strb_q <= flit_data[DATA_WIDTH/8-1:0];
   end

   assign write_strb = burst ? '1 : strb_q;  // Bursts write full words

endmodule

// ==== mam_rdata.sv ====
`timescale 1ns/1ps

module mam_rdata #(
   parameter int DATA_WIDTH = 32
) (
   input  logic [DATA_WIDTH-1:0]           read_data,
   input  logic [$clog2(DATA_WIDTH/8)-1:0] word_idx,
   input  logic [1:0]                      hdr_sel,
   input  logic [9:0]                      id,
   input  logic                            out_valid,
   input  logic                            out_last,
   output mam_pkg::dii_flit_t              debug_out
);

   localparam int WORDS = DATA_WIDTH/16;

   int slice;                              // Word 0 is the MS slice

   assign slice = WORDS - 1 - int'(word_idx);

   always_comb begin
      debug_out.valid = out_valid;
      debug_out.last = out_last;
      case (hdr_sel)
         mam_pkg::SEL_DEST: debug_out.data = 16'h0000;
         mam_pkg::SEL_SRC:  debug_out.data = {mam_pkg::SRC_TYPE, id};
         default:           debug_out.data = read_data[16*slice +: 16];
      endcase
   end

endmodule

// ==== mam_mem.sv ====
`timescale 1ns/1ps

module mam_mem #(
   parameter int DATA_WIDTH = 32,
   parameter int MEM_WORDS  = 64
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    req_valid,
   input  mam_pkg::mem_req_t       mem_req,
   input  logic                    write_valid,
   input  logic [DATA_WIDTH-1:0]   write_data,
   input  logic [DATA_WIDTH/8-1:0] write_strb,
   input  logic                    read_ready,
   output logic                    req_ready,
   output logic                    write_ready,
   output logic                    read_valid,
   output logic [DATA_WIDTH-1:0]   read_data
);

   localparam int OFFSET = $clog2(DATA_WIDTH/8);
   localparam int AW = $clog2(MEM_WORDS);

   typedef enum logic [1:0] {M_IDLE, M_WRITE, M_READ} mem_state_e;

   mem_state_e            state;
   logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
   logic [AW-1:0]         word_addr;
   logic [AW-1:0]         next_addr;
   logic [AW-1:0]         req_word;
   logic [13:0]           beats_left;
   logic                  start;

   assign req_word = mem_req.addr[OFFSET +: AW];  // Byte address to word, wraps
   assign next_addr = word_addr + 1'b1;
   assign start = (state == M_IDLE) && req_valid;
   assign req_ready = state == M_IDLE;
   assign write_ready = state == M_WRITE;
   assign read_valid = state == M_READ;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= M_IDLE;
         word_addr <= '0;
         beats_left <= '0;
      end else if (start) begin
         state <= (mem_req.op == mam_pkg::OP_WRITE) ? M_WRITE : M_READ;
         word_addr <= req_word;
         beats_left <= mem_req.burst ? mem_req.beats : 14'd1;
      end else if ((state == M_WRITE && write_valid) || (state == M_READ && read_ready)) begin
         word_addr <= next_addr;
         beats_left <= beats_left - 1'b1;
         if (beats_left == 14'd1) state <= M_IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (start) read_data <= mem[req_word];
      else if (state == M_READ && read_ready) read_data <= mem[next_addr];
      if (state == M_WRITE && write_valid) begin
         for (int b = 0; b < DATA_WIDTH/8; b++) begin
            if (write_strb[b]) mem[word_addr][8*b +: 8] <= write_data[8*b +: 8];
         end
      end
   end

endmodule

// ==== mam_ctrl.sv ====
`timescale 1ns/1ps

module mam_ctrl #(
   parameter int DATA_WIDTH = 32
) (
   input  logic                clk,
   input  logic                rst,
   input  mam_pkg::dii_flit_t  debug_in,
   input  logic                debug_out_ready,
   input  logic                req_ready,
   input  logic                write_ready,
   input  logic                read_valid,
   input  logic                addr_done,
   input  logic                wpkt_hdr_done,
   input  logic                word_done,
   input  logic                pkt_full,
   input  logic                beat_last,
   output logic                debug_in_ready,
   output logic                out_valid,
   output logic                out_last,
   output logic [1:0]          hdr_sel,
   output logic                req_valid,
   output mam_pkg::mem_req_t   mem_req,
   output logic                write_valid,
   output logic                read_ready,
   output logic                shift,
   output logic                strb_load,
   output logic                flit_clr,
   output logic                flit_inc,
   output logic                word_clr,
   output logic                word_inc,
   output logic                beat_load,
   output logic                beat_dec
);

   localparam bit WIDE = DATA_WIDTH > 16;  // More than one flit per word

   mam_pkg::mam_state_e state, nxt_state;
   logic in_packet;                        // Write data continues in current packet

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= mam_pkg::ST_IDLE;
         in_packet <= 1'b0;
      end else begin
         state <= nxt_state;
         if (state == mam_pkg::ST_WRITE && debug_in.valid && word_done)
            in_packet <= !debug_in.last;
      end
   end

   always_ff @(posedge clk) begin
      if (state == mam_pkg::ST_CMD && debug_in.valid) begin
         mem_req.op <= mam_pkg::mam_op_e'(debug_in.data[15]);
         mem_req.burst <= debug_in.data[14];
         mem_req.beats <= debug_in.data[14] ? debug_in.data[13:0] : 14'd1;
      end
      if (state == mam_pkg::ST_ADDR && debug_in.valid)
         mem_req.addr <= {debug_in.data, mem_req.addr[mam_pkg::ADDR_WIDTH-1:16]};
   end

   always_comb begin
      nxt_state = state;
      debug_in_ready = 1'b0;
      out_valid = 1'b0;
      out_last = 1'b0;
      hdr_sel = mam_pkg::SEL_DATA;
      req_valid = 1'b0;
      write_valid = 1'b0;
      read_ready = 1'b0;
      shift = 1'b0;
      strb_load = 1'b0;
      flit_clr = 1'b0;
      flit_inc = 1'b0;
      word_clr = 1'b0;
      word_inc = 1'b0;
      beat_load = 1'b0;
      beat_dec = 1'b0;
      case (state)
         mam_pkg::ST_IDLE, mam_pkg::ST_HDR_SKIP: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid)
               nxt_state = (state == mam_pkg::ST_IDLE) ? mam_pkg::ST_HDR_SKIP : mam_pkg::ST_CMD;
         end
         mam_pkg::ST_CMD: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               strb_load = 1'b1;
               flit_clr = 1'b1;
               nxt_state = mam_pkg::ST_ADDR;
            end
         end
         mam_pkg::ST_ADDR: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               flit_inc = 1'b1;
               if (addr_done) nxt_state = mam_pkg::ST_REQUEST;
            end
         end
         mam_pkg::ST_REQUEST: begin
            req_valid = 1'b1;
            if (req_ready) begin
               beat_load = 1'b1;
               flit_clr = 1'b1;
               word_clr = 1'b1;
               if (mem_req.op == mam_pkg::OP_READ) nxt_state = mam_pkg::ST_RPKT_HDR;
               else if (mem_req.burst) nxt_state = mam_pkg::ST_WPKT_HDR;
               else nxt_state = mam_pkg::ST_WSINGLE;
            end
         end
         mam_pkg::ST_WPKT_HDR: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               flit_inc = 1'b1;
               if (wpkt_hdr_done) nxt_state = mam_pkg::ST_WRITE;
            end
         end
         mam_pkg::ST_WRITE, mam_pkg::ST_WSINGLE: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               shift = 1'b1;
               word_inc = WIDE && !word_done;
               word_clr = word_done;
               if (word_done) begin
                  nxt_state = (state == mam_pkg::ST_WRITE) ? mam_pkg::ST_WRITE_WAIT
                                                           : mam_pkg::ST_WSINGLE_WAIT;
               end else if (debug_in.last && state == mam_pkg::ST_WRITE) begin
                  flit_clr = 1'b1;                 // Word spans into next packet
                  nxt_state = mam_pkg::ST_WPKT_HDR;
               end
            end
         end
         mam_pkg::ST_WRITE_WAIT: begin
            write_valid = 1'b1;
            if (write_ready) begin
               beat_dec = 1'b1;
               if (beat_last) begin
                  nxt_state = mam_pkg::ST_IDLE;
               end else if (in_packet) begin
                  nxt_state = mam_pkg::ST_WRITE;
               end else begin
                  flit_clr = 1'b1;
                  nxt_state = mam_pkg::ST_WPKT_HDR;
               end
            end
         end
         mam_pkg::ST_WSINGLE_WAIT: begin
            write_valid = 1'b1;
            if (write_ready) nxt_state = mam_pkg::ST_IDLE;
         end
         mam_pkg::ST_RPKT_HDR: begin
            out_valid = 1'b1;
            hdr_sel = wpkt_hdr_done ? mam_pkg::SEL_SRC : mam_pkg::SEL_DEST;
            if (debug_out_ready) begin
               flit_inc = 1'b1;
               if (wpkt_hdr_done) nxt_state = mam_pkg::ST_READ;
            end
         end
         mam_pkg::ST_READ: begin
            out_valid = read_valid;
            out_last = pkt_full || (word_done && beat_last);
            if (read_valid && debug_out_ready) begin
               word_inc = WIDE && !word_done;
               word_clr = word_done;
               read_ready = word_done;         // Release beat on its last flit
               beat_dec = word_done;
               flit_inc = !pkt_full;
               flit_clr = pkt_full;
               if (word_done && beat_last) nxt_state = mam_pkg::ST_IDLE;
               else if (pkt_full) nxt_state = mam_pkg::ST_RPKT_HDR;
            end
         end
         default: nxt_state = mam_pkg::ST_IDLE;
      endcase
   end

endmodule

// ==== mam_top.sv ====
`timescale 1ns/1ps

module mam_top #(
   parameter int DATA_WIDTH  = 32,
   parameter int MAX_PKT_LEN = 8,
   parameter int MEM_WORDS   = 64
) (
   input  logic               clk,
   input  logic               rst,
   input  mam_pkg::dii_flit_t debug_in,
   output logic               debug_in_ready,
   output mam_pkg::dii_flit_t debug_out,
   input  logic               debug_out_ready,
   input  logic [9:0]         id
);

   localparam int WW = $clog2(DATA_WIDTH/8);

   mam_pkg::mem_req_t       mem_req;
   logic                    req_valid, req_ready;
   logic                    write_valid, write_ready;
   logic                    read_valid, read_ready;
   logic [DATA_WIDTH-1:0]   write_data, read_data;
   logic [DATA_WIDTH/8-1:0] write_strb;
   logic                    out_valid, out_last;
   logic [1:0]              hdr_sel;
   logic                    shift, strb_load;
   logic                    flit_clr, flit_inc, word_clr, word_inc, beat_load, beat_dec;
   logic                    addr_done, wpkt_hdr_done, word_done, pkt_full, beat_last;
   logic [WW-1:0]           word_idx;

   mam_ctrl #(.DATA_WIDTH(DATA_WIDTH)) ctrl0 (
      .clk, .rst, .debug_in, .debug_out_ready, .req_ready, .write_ready, .read_valid,
      .addr_done, .wpkt_hdr_done, .word_done, .pkt_full, .beat_last,
      .debug_in_ready, .out_valid, .out_last, .hdr_sel, .req_valid, .mem_req,
      .write_valid, .read_ready, .shift, .strb_load,
      .flit_clr, .flit_inc, .word_clr, .word_inc, .beat_load, .beat_dec);

   mam_counter #(.DATA_WIDTH(DATA_WIDTH), .MAX_PKT_LEN(MAX_PKT_LEN)) counter0 (
      .clk, .rst, .flit_clr, .flit_inc, .word_clr, .word_inc, .beat_load, .beat_dec,
      .beats(mem_req.beats), .word_idx,
      .addr_done, .wpkt_hdr_done, .word_done, .pkt_full, .beat_last);

   mam_wdata #(.DATA_WIDTH(DATA_WIDTH)) wdata0 (
      .clk, .flit_data(debug_in.data), .shift, .strb_load, .burst(mem_req.burst),
      .write_data, .write_strb);

   mam_rdata #(.DATA_WIDTH(DATA_WIDTH)) rdata0 (
      .read_data, .word_idx, .hdr_sel, .id, .out_valid, .out_last, .debug_out);

   mam_mem #(.DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)) mem0 (
      .clk, .rst, .req_valid, .mem_req, .write_valid, .write_data, .write_strb,
      .read_ready, .req_ready, .write_ready, .read_valid, .read_data);

endmodule

// ==== mam_top_checker.sv ====
`timescale 1ns/1ps

module mam_top_checker (
   input logic               clk,
   input logic               rst,
   input mam_pkg::dii_flit_t debug_out,
   input logic               debug_out_ready,
   input logic               req_valid,
   input logic               req_ready,
   input logic               read_valid,
   input logic               read_ready
);

   int unsigned fail_cnt = 0;

   stalled_flit_stable: assert property (@(posedge clk) disable iff (rst)
      debug_out.valid && !debug_out_ready |=> $stable(debug_out))
      else begin
         $error("debug_out changed while the host stalled it");
         fail_cnt++;
      end

   req_held: assert property (@(posedge clk) disable iff (rst)
      req_valid && !req_ready |=> req_valid)
      else begin
         $error("req_valid dropped before req_ready");
         fail_cnt++;
      end

   read_ready_with_valid: assert property (@(posedge clk) disable iff (rst)
      read_ready |-> read_valid)
      else begin
         $error("read_ready without read_valid");
         fail_cnt++;
      end

   out_idle_after_reset: assert property (@(posedge clk)
      rst |=> !debug_out.valid)
      else begin
         $error("debug_out.valid high right after reset");
         fail_cnt++;
      end

endmodule

bind mam_top mam_top_checker chk0 (
   .clk, .rst, .debug_out, .debug_out_ready, .req_valid, .req_ready, .read_valid, .read_ready);

// ==== mam_top_tb.sv ====
`timescale 1ns/1ps

module mam_top_tb;

   localparam int DW          = 32;
   localparam int MAX_PKT_LEN = 8;
   localparam int MEM_WORDS   = 64;
   localparam int WORD_FLITS  = DW/16;
   localparam int DATA_FLITS  = MAX_PKT_LEN - mam_pkg::HDR_FLITS;
   localparam int MAX_CYCLES  = 20000;     // Well above all test traffic

   logic               clk = 1'b0;
   logic               rst;
   mam_pkg::dii_flit_t debug_in;
   logic               debug_in_ready;
   mam_pkg::dii_flit_t debug_out;
   logic               debug_out_ready;
   logic [9:0]         id;

   logic [DW-1:0] model [MEM_WORDS];       // Reference memory
   int            in_gap, out_gap;         // Idle chance in percent
   int            cycles = 0;
   string         test_name;

   mam_top #(.DATA_WIDTH(DW), .MAX_PKT_LEN(MAX_PKT_LEN), .MEM_WORDS(MEM_WORDS)) dut0 (
      .clk, .rst, .debug_in, .debug_in_ready, .debug_out, .debug_out_ready, .id);

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles > MAX_CYCLES)
         abort_run("Timeout: the tests did not finish within the cycle limit");
      else if (dut0.chk0.fail_cnt != 0)
         abort_run("A protocol assertion in mam_top_checker failed");
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped on error");
   endtask

   function automatic int word_index(input logic [31:0] addr, input int beat);
      return int'((addr / (DW/8) + 32'(beat)) % MEM_WORDS);
   endfunction

   task automatic send_flit(input logic [15:0] data, input logic last);
      logic taken;
      while ($urandom_range(99, 0) < in_gap) begin
         debug_in.valid = 1'b0;
         @(posedge clk);
         #1;
      end
      debug_in = {1'b1, last, data};
      taken = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = debug_in_ready;
         @(posedge clk);
         #1;
      end
      debug_in.valid = 1'b0;
   endtask

   task automatic send_packet(input logic [15:0] pkt[$]);
      for (int i = 0; i < pkt.size(); i++)
         send_flit(pkt[i], i == pkt.size() - 1);
   endtask

   task automatic take_flit(output logic [16:0] flit);
      logic taken;
      taken = 1'b0;
      while (!taken) begin
         debug_out_ready = $urandom_range(99, 0) >= out_gap;
         @(negedge clk);
         taken = debug_out.valid && debug_out_ready;
         flit = {debug_out.last, debug_out.data};
         @(posedge clk);
         #1;
      end
      debug_out_ready = 1'b0;
   endtask

   task automatic send_request(input mam_pkg::mam_op_e op, input logic burst,
                               input logic [13:0] field, input logic [31:0] addr,
                               input logic with_data, input logic [DW-1:0] data);
      logic [15:0] pkt[$];
      logic [15:0] cmd;
      cmd = {op, burst, field};
      pkt.push_back(16'h0000);
      pkt.push_back(16'h0000);
      pkt.push_back(cmd);
      pkt.push_back(addr[15:0]);             // LS address word first
      pkt.push_back(addr[31:16]);
      if (with_data) begin
         for (int f = 0; f < WORD_FLITS; f++) pkt.push_back(data[DW-1-16*f -: 16]);
      end
      send_packet(pkt);
   endtask

   task automatic write_single(input logic [31:0] addr, input logic [DW/8-1:0] strb);
      logic [DW-1:0] data;
      int idx;
      data = $urandom();
      idx = word_index(addr, 0);
      for (int b = 0; b < DW/8; b++) begin
         if (strb[b]) model[idx][8*b +: 8] = data[8*b +: 8];
      end
      send_request(mam_pkg::OP_WRITE, 1'b0, 14'(strb), addr, 1'b1, data);
   endtask

   // Empty chunk list gives random packet splits
   task automatic write_burst(input logic [31:0] addr, input int beats, input int chunks[$]);
      logic [15:0] data_q[$];
      logic [15:0] pkt[$];
      logic [DW-1:0] word;
      int chunk;
      for (int b = 0; b < beats; b++) begin
         word = $urandom();
         model[word_index(addr, b)] = word;
         for (int f = 0; f < WORD_FLITS; f++) data_q.push_back(word[DW-1-16*f -: 16]);
      end
      send_request(mam_pkg::OP_WRITE, 1'b1, 14'(beats), addr, 1'b0, '0);
      while (data_q.size() > 0) begin
         chunk = (chunks.size() > 0) ? chunks.pop_front() : int'($urandom_range(7, 1));
         if (chunk > data_q.size()) chunk = data_q.size();
         pkt.delete();
         pkt.push_back(16'h0000);
         pkt.push_back(16'h0000);
         repeat (chunk) pkt.push_back(data_q.pop_front());
         send_packet(pkt);
      end
   endtask

   task automatic read_check(input logic [31:0] addr, input int beats, input logic burst);
      logic [16:0] exp_q[$];
      logic [16:0] got;
      logic [DW-1:0] word;
      int total;
      total = beats * WORD_FLITS;
      for (int p = 0; p < total; p++) begin
         word = model[word_index(addr, p / WORD_FLITS)];
         if (p % DATA_FLITS == 0) begin
            exp_q.push_back(17'h0_0000);
            exp_q.push_back({1'b0, mam_pkg::SRC_TYPE, id});
         end
         exp_q.push_back({(p % DATA_FLITS == DATA_FLITS - 1) || (p == total - 1),
                          word[DW-1-16*(p % WORD_FLITS) -: 16]});
      end
      send_request(mam_pkg::OP_READ, burst, burst ? 14'(beats) : 14'd0, addr, 1'b0, '0);
      for (int i = 0; i < exp_q.size(); i++) begin
         take_flit(got);
         assert (got == exp_q[i])
            else abort_run($sformatf("[FAIL] %s: flit %0d expected %h, actual %h",
                                     test_name, i, exp_q[i], got));
      end
      debug_out_ready = 1'b1;
      @(negedge clk);
      assert (!debug_out.valid)
         else abort_run($sformatf("%s: DUT sent a flit after the end of the read", test_name));
      @(posedge clk);
      #1;
      debug_out_ready = 1'b0;
   endtask

   initial begin
      int split[$];
      logic [31:0] addr;
      int beats;
      void'($urandom(32'h298b_05a3));
      rst = 1'b1;
      debug_in = '0;
      debug_out_ready = 1'b0;
      id = 10'h2c5;
      in_gap = 0;
      out_gap = 0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;

      test_name = "reset";
      @(negedge clk);
      assert (debug_in_ready && !debug_out.valid)
         else abort_run($sformatf("[FAIL] reset: ready/valid expected 10, actual %b%b",
                                  debug_in_ready, debug_out.valid));
      @(posedge clk);
      #1;

      test_name = "fill";
      write_burst(32'h0000_0000, MEM_WORDS, split);

      test_name = "single_write";
      write_single(32'h0000_0014, 4'b0101);
      read_check(32'h0000_0014, 1, 1'b0);

      test_name = "burst_write";
      split = {3, 4, 1, 6, 5, 1};              // Mid-word and word-aligned packet ends
      write_burst(32'h0000_0040, 10, split);
      read_check(32'h0000_0040, 10, 1'b1);

      test_name = "long_read";
      read_check(32'h0000_00e0, 23, 1'b1);     // Wraps past the top word

      test_name = "random_gaps";
      split.delete();
      in_gap = 30;
      out_gap = 40;
      repeat (6) begin
         addr = $urandom();
         beats = $urandom_range(12, 1);
         write_burst(addr, beats, split);
         read_check(addr, beats, 1'b1);
         addr = $urandom();
         write_single(addr, 4'($urandom_range(15, 0)));
         read_check(addr, 1, 1'b0);
      end

      if (dut0.chk0.fail_cnt == 0) begin
         $display("TEST PASS");
         $finish;
      end else begin
         abort_run("A protocol assertion in mam_top_checker failed");
      end
   end

endmodule

// ==== mam_top.f ====
mam_pkg.sv
mam_counter.sv
mam_wdata.sv
mam_rdata.sv
mam_mem.sv
mam_ctrl.sv
mam_top.sv
mam_top_checker.sv
mam_top_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mam_top_tb -f mam_top.f

out=$(./obj_dir/Vmam_top_tb +verilator+error+limit+100 2>&1) || true
echo "$out"
echo "$out" | grep -qx "TEST PASS"
